/* src/vis_defs.svh */
`ifndef VIS_DEFS_SVH
`define VIS_DEFS_SVH

// Radio channels carried by each sample word
`define VIS_CHANS 8

// Correlator units in one chain
`define VIS_LENGTH 4

// Longest frame in samples
`define VIS_FRAME_MAX 16

// Signed partial sum width
// Each sample adds at most 2, so a full frame reaches +/-32
`define VIS_ADDER 7

// Frames summed into one visibility
`define VIS_COUNT 4

// Signed visibility width, two bits of growth over VIS_COUNT frames
`define VIS_ACCUM (`VIS_ADDER + 2)

// Latency of the source delay line in cycles
`define VIS_DELAY 2

`endif

/* src/sig_pkg.sv */
`include "vis_defs.svh"

package sig_pkg;

  // One plane of a sample, either I or Q
  // Bit n belongs to radio channel n
  // A bit of 1 stands for +1 and a bit of 0 for -1
  typedef logic [`VIS_CHANS-1:0] sig_word_t;

endpackage

/* src/vis_pkg.sv */
`include "vis_defs.svh"

package vis_pkg;

  // Sum of one-bit complex products over a single frame
  // Per-sample terms lie in {-2, 0, +2}
  typedef logic signed [`VIS_ADDER-1:0] partial_t;

  // Visibility summed over VIS_COUNT frames
  typedef logic signed [`VIS_ACCUM-1:0] vis_t;

  // Position of a correlator unit in the chain
  // Kept at least one bit wide for a single-unit chain
  typedef logic [(`VIS_LENGTH > 1 ? $clog2(`VIS_LENGTH) : 1)-1:0] unit_idx_t;

endpackage

/* src/sig_delay.sv */
`timescale 1ns/100ps

`include "vis_defs.svh"

module sig_delay import sig_pkg::*; (
  input  logic      clock,
  input  logic      rst_i,

  // Undelayed source signals
  input  logic      valid_i,
  input  logic      first_i,
  input  logic      last_i,
  input  sig_word_t dati_i,
  input  sig_word_t datq_i,

  // Same signals VIS_DELAY cycles later, for the next chain
  output logic      valid_o,
  output logic      first_o,
  output logic      last_o,
  output sig_word_t dati_o,
  output sig_word_t datq_o
);

  // Stage 0 is nearest the input
  logic [`VIS_DELAY-1:0] valid_q;
  logic [`VIS_DELAY-1:0] first_q;
  logic [`VIS_DELAY-1:0] last_q;
  sig_word_t             dati_q [`VIS_DELAY];
  sig_word_t             datq_q [`VIS_DELAY];

  // Strobe and frame flags
  always_ff @(posedge clock) begin
    if (rst_i) begin
      valid_q <= '0;
      first_q <= '0;
      last_q  <= '0;
    end else begin
      valid_q[0] <= valid_i;
      first_q[0] <= first_i;
      last_q[0]  <= last_i;
      for (int s = 1; s < `VIS_DELAY; s++) begin
        valid_q[s] <= valid_q[s-1];
        first_q[s] <= first_q[s-1];
        last_q[s]  <= last_q[s-1];
      end
    end
  end

  // Sample planes move along with the flags
  always_ff @(posedge clock) begin
    dati_q[0] <= dati_i;
    datq_q[0] <= datq_i;
    for (int s = 1; s < `VIS_DELAY; s++) begin
      dati_q[s] <= dati_q[s-1];
      datq_q[s] <= datq_q[s-1];
    end
  end

  assign valid_o = valid_q[`VIS_DELAY-1];
  assign first_o = first_q[`VIS_DELAY-1];
  assign last_o  = last_q[`VIS_DELAY-1];
  assign dati_o  = dati_q[`VIS_DELAY-1];
  assign datq_o  = datq_q[`VIS_DELAY-1];

endmodule

/* src/correlator.sv */
`timescale 1ns/100ps

`include "vis_defs.svh"

module correlator import sig_pkg::*, vis_pkg::*; #(
  // Channel A, taken as is
  parameter int ACHAN = 0,
  // Channel B, taken as conjugate
  parameter int BCHAN = 1
) (
  input  logic      clock,
  input  logic      rst_i,

  // Source samples, shared by every unit
  input  logic      valid_i,
  input  logic      first_i,
  input  logic      last_i,
  input  sig_word_t dati_i,
  input  sig_word_t datq_i,

  // Frame result, one pulse after the last sample
  output logic      valid_o,
  output partial_t  re_o,
  output partial_t  im_o
);

  // Selected channel bits
  logic     ai;
  logic     aq;
  logic     bi;
  logic     bq;

  // Product of the current sample
  partial_t re_prod;
  partial_t im_prod;

  // Running sums and their next values
  partial_t re_sum_q;
  partial_t im_sum_q;
  partial_t re_next;
  partial_t im_next;

  assign ai = dati_i[ACHAN];
  assign aq = datq_i[ACHAN];
  assign bi = dati_i[BCHAN];
  assign bq = datq_i[BCHAN];

  // Real part AI*BI + AQ*BQ
  // A term is +1 when its two bits agree
  always_comb begin
    case ({ai ~^ bi, aq ~^ bq})
      2'b11:   re_prod = partial_t'(2);
      2'b00:   re_prod = partial_t'(-2);
      default: re_prod = '0;
    endcase
  end

  // Imaginary part AQ*BI - AI*BQ
  always_comb begin
    case ({aq ~^ bi, ai ~^ bq})
      2'b10:   im_prod = partial_t'(2);
      2'b01:   im_prod = partial_t'(-2);
      default: im_prod = '0;
    endcase
  end

  // First sample restarts the frame sum
  assign re_next = first_i ? re_prod : re_sum_q + re_prod;
  assign im_next = first_i ? im_prod : im_sum_q + im_prod;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      re_sum_q <= '0;
      im_sum_q <= '0;
      valid_o  <= 1'b0;
    end else begin
      valid_o <= valid_i && last_i;
      if (valid_i) begin
        re_sum_q <= re_next;
        im_sum_q <= im_next;
      end
    end
  end

  // Frame result held until the next last sample
  always_ff @(posedge clock) begin
    if (valid_i && last_i) begin
      re_o <= re_next;
      im_o <= im_next;
    end
  end

endmodule

/* src/vis_merge.sv */
`timescale 1ns/100ps

`include "vis_defs.svh"

module vis_merge import vis_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_i,

  // Parallel frame results, one strobe per unit
  input  logic [`VIS_LENGTH-1:0] par_valid_i,
  input  partial_t               par_re_i [`VIS_LENGTH],
  input  partial_t               par_im_i [`VIS_LENGTH],

  // Same results, one per cycle, unit 0 first
  output logic                   seq_valid_o,
  output partial_t               seq_re_o,
  output partial_t               seq_im_o
);

  localparam unit_idx_t LAST_IDX = unit_idx_t'(`VIS_LENGTH - 1);

  // Capture bank
  partial_t  re_q [`VIS_LENGTH];
  partial_t  im_q [`VIS_LENGTH];

  // Read position and emission window
  unit_idx_t rd_idx_q;
  logic      busy_q;

  // Each unit loads its own slot
  always_ff @(posedge clock) begin
    for (int k = 0; k < `VIS_LENGTH; k++) begin
      if (par_valid_i[k]) begin
        re_q[k] <= par_re_i[k];
        im_q[k] <= par_im_i[k];
      end
    end
  end

  // Units strobe together, so unit 0 starts the window
  always_ff @(posedge clock) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      rd_idx_q <= '0;
    end else if (par_valid_i[0]) begin
      busy_q   <= 1'b1;
      rd_idx_q <= '0;
    end else if (busy_q) begin
      // Window closes after the last unit
      if (rd_idx_q == LAST_IDX) begin
        busy_q   <= 1'b0;
        rd_idx_q <= '0;
      end else begin
        rd_idx_q <= rd_idx_q + 1'b1;
      end
    end
  end

  // One slot per busy cycle
  assign seq_valid_o = busy_q;
  assign seq_re_o    = re_q[rd_idx_q];
  assign seq_im_o    = im_q[rd_idx_q];

endmodule

/* src/vis_accum.sv */
`timescale 1ns/100ps

`include "vis_defs.svh"

module vis_accum import vis_pkg::*; (
  input  logic     clock,
  input  logic     rst_i,

  // Partial sums in unit order
  input  logic     valid_i,
  input  partial_t re_i,
  input  partial_t im_i,

  // Finished visibilities, once per group of frames
  output logic     vis_valid_o,
  output logic     vis_first_o,
  output logic     vis_last_o,
  output vis_t     vis_re_o,
  output vis_t     vis_im_o
);

  localparam int FRAME_W = (`VIS_COUNT > 1) ? $clog2(`VIS_COUNT) : 1;
  localparam unit_idx_t LAST_UNIT = unit_idx_t'(`VIS_LENGTH - 1);
  localparam logic [FRAME_W-1:0] LAST_FRAME = FRAME_W'(`VIS_COUNT - 1);

  // One running sum per unit
  vis_t               acc_re_q [`VIS_LENGTH];
  vis_t               acc_im_q [`VIS_LENGTH];

  // Item and frame position
  unit_idx_t          unit_q;
  logic [FRAME_W-1:0] frame_q;
  logic               first_frame;
  logic               last_frame;

  // Widened inputs and updated sums
  vis_t               re_ext;
  vis_t               im_ext;
  vis_t               re_sum;
  vis_t               im_sum;

  // Sign extension to visibility width
  assign re_ext = vis_t'(re_i);
  assign im_ext = vis_t'(im_i);

  assign first_frame = (frame_q == '0);
  assign last_frame  = (frame_q == LAST_FRAME);

  // Frame 0 starts a new group
  assign re_sum = first_frame ? re_ext : acc_re_q[unit_q] + re_ext;
  assign im_sum = first_frame ? im_ext : acc_im_q[unit_q] + im_ext;

  // Unit count wraps at VIS_LENGTH, frame count at VIS_COUNT
  always_ff @(posedge clock) begin
    if (rst_i) begin
      unit_q  <= '0;
      frame_q <= '0;
    end else if (valid_i) begin
      if (unit_q == LAST_UNIT) begin
        unit_q  <= '0;
        frame_q <= last_frame ? '0 : frame_q + 1'b1;
      end else begin
        unit_q  <= unit_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (valid_i) begin
      acc_re_q[unit_q] <= re_sum;
      acc_im_q[unit_q] <= im_sum;
    end
  end

  // Totals go out only in the last frame
  always_ff @(posedge clock) begin
    if (rst_i) begin
      vis_valid_o <= 1'b0;
      vis_first_o <= 1'b0;
      vis_last_o  <= 1'b0;
    end else begin
      vis_valid_o <= valid_i && last_frame;
      vis_first_o <= valid_i && last_frame && (unit_q == '0);
      vis_last_o  <= valid_i && last_frame && (unit_q == LAST_UNIT);
    end
  end

  always_ff @(posedge clock) begin
    if (valid_i && last_frame) begin
      vis_re_o <= re_sum;
      vis_im_o <= im_sum;
    end
  end

endmodule

/* src/vis_chain.sv */
`timescale 1ns/100ps

`include "vis_defs.svh"

module vis_chain import sig_pkg::*, vis_pkg::*; (
  // Visibility clock domain
  input  logic      clock,
  input  logic      rst_i,

  // Source signals from upstream
  input  logic      sig_valid_i,
  input  logic      sig_first_i,
  input  logic      sig_last_i,
  input  sig_word_t sig_dati_i,
  input  sig_word_t sig_datq_i,

  // Delayed source signals for the next chain
  output logic      sig_valid_o,
  output logic      sig_first_o,
  output logic      sig_last_o,
  output sig_word_t sig_dati_o,
  output sig_word_t sig_datq_o,

  // Accumulated visibilities
  output logic      vis_valid_o,
  output logic      vis_first_o,
  output logic      vis_last_o,
  output vis_t      vis_re_o,
  output vis_t      vis_im_o
);

  // Parallel frame results
  logic [`VIS_LENGTH-1:0] unit_valid_w;
  partial_t               unit_re_w [`VIS_LENGTH];
  partial_t               unit_im_w [`VIS_LENGTH];

  // Sequenced results into the accumulator
  logic                   seq_valid_w;
  partial_t               seq_re_w;
  partial_t               seq_im_w;

  // Source pass-through
  sig_delay u_delay (
    .clock  (clock),
    .rst_i  (rst_i),
    .valid_i(sig_valid_i),
    .first_i(sig_first_i),
    .last_i (sig_last_i),
    .dati_i (sig_dati_i),
    .datq_i (sig_datq_i),
    .valid_o(sig_valid_o),
    .first_o(sig_first_o),
    .last_o (sig_last_o),
    .dati_o (sig_dati_o),
    .datq_o (sig_datq_o)
  );

  // Unit k pairs channel k with channel k+1
  // All units see the undelayed samples
  generate
    for (genvar ii = 0; ii < `VIS_LENGTH; ii++) begin : gen_corr
      correlator #(
        .ACHAN(ii),
        .BCHAN(ii + 1)
      ) u_corr (
        .clock  (clock),
        .rst_i  (rst_i),
        .valid_i(sig_valid_i),
        .first_i(sig_first_i),
        .last_i (sig_last_i),
        .dati_i (sig_dati_i),
        .datq_i (sig_datq_i),
        .valid_o(unit_valid_w[ii]),
        .re_o   (unit_re_w[ii]),
        .im_o   (unit_im_w[ii])
      );
    end
  endgenerate

  // Parallel to sequential
  vis_merge u_merge (
    .clock      (clock),
    .rst_i      (rst_i),
    .par_valid_i(unit_valid_w),
    .par_re_i   (unit_re_w),
    .par_im_i   (unit_im_w),
    .seq_valid_o(seq_valid_w),
    .seq_re_o   (seq_re_w),
    .seq_im_o   (seq_im_w)
  );

  // Sum over VIS_COUNT frames
  vis_accum u_accum (
    .clock      (clock),
    .rst_i      (rst_i),
    .valid_i    (seq_valid_w),
    .re_i       (seq_re_w),
    .im_i       (seq_im_w),
    .vis_valid_o(vis_valid_o),
    .vis_first_o(vis_first_o),
    .vis_last_o (vis_last_o),
    .vis_re_o   (vis_re_o),
    .vis_im_o   (vis_im_o)
  );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
  output logic clock_o,
  output logic rst_o
);

  // 40 ns period
  initial begin
    clock_o = 1'b0;
    forever #20 clock_o = ~clock_o;
  end

  // Held over two rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clock_o);
    @(negedge clock_o);
    rst_o = 1'b0;
  end

endmodule

/* bench/vis_chain_checker.sv */
`timescale 1ns/100ps

`include "vis_defs.svh"

module vis_chain_checker import vis_pkg::*; (
  input logic                   clock,
  input logic                   rst_i,
  // Source strobe before and after the delay line
  input logic                   src_valid_i,
  input logic                   fwd_valid_i,
  // Visibility output
  input logic                   vis_valid_i,
  input logic                   vis_first_i,
  input logic                   vis_last_i,
  // Merge side
  input logic [`VIS_LENGTH-1:0] unit_valid_i,
  input logic                   merge_busy_i,
  input unit_idx_t              merge_idx_i
);

  localparam unit_idx_t LAST_IDX = unit_idx_t'(`VIS_LENGTH - 1);

  // Read by the testbench for its closing summary
  int unsigned fail_count = 0;

  first_has_valid: assert property (@(posedge clock) disable iff (rst_i)
    vis_first_i |-> vis_valid_i)
    else begin
      fail_count++;
      $error("vis_first_o is high while vis_valid_o is low");
    end

  last_has_valid: assert property (@(posedge clock) disable iff (rst_i)
    vis_last_i |-> vis_valid_i)
    else begin
      fail_count++;
      $error("vis_last_o is high while vis_valid_o is low");
    end

  // Strobe leaves the delay line exactly VIS_DELAY cycles later
  delay_strobe: assert property (@(posedge clock) disable iff (rst_i)
    fwd_valid_i == $past(src_valid_i, `VIS_DELAY))
    else begin
      fail_count++;
      $error("sig_valid_o does not follow sig_valid_i by the line delay");
    end

  // Last slot is still read in the capture cycle, so that one is allowed
  merge_free: assert property (@(posedge clock) disable iff (rst_i)
    unit_valid_i[0] |-> (!merge_busy_i || merge_idx_i == LAST_IDX))
    else begin
      fail_count++;
      $error("new frame results arrived while the merge was still emitting");
    end

  quiet_after_reset: assert property (@(posedge clock)
    $past(rst_i) |-> !vis_valid_i)
    else begin
      fail_count++;
      $error("vis_valid_o was high in the cycle after reset");
    end

endmodule

bind vis_chain vis_chain_checker u_checker (
  .clock       (clock),
  .rst_i       (rst_i),
  .src_valid_i (sig_valid_i),
  .fwd_valid_i (sig_valid_o),
  .vis_valid_i (vis_valid_o),
  .vis_first_i (vis_first_o),
  .vis_last_i  (vis_last_o),
  .unit_valid_i(unit_valid_w),
  .merge_busy_i(u_merge.busy_q),
  .merge_idx_i (u_merge.rd_idx_q)
);

/* bench/vis_chain_tb.sv */
`timescale 1ns/100ps

`include "vis_defs.svh"

module vis_chain_tb import sig_pkg::*, vis_pkg::*; ();

  localparam int RAND_GROUPS = 3;
  // Idle cycles after a frame
  localparam int MAX_GAP = 6;
  // Random groups, two extreme groups, the broken group, the group after it
  localparam int GROUPS = RAND_GROUPS + 4;
  localparam int CYCLE_LIMIT = GROUPS * `VIS_COUNT * (`VIS_FRAME_MAX + MAX_GAP) + 200;
  localparam int MODE_RANDOM = 0;
  localparam int MODE_SAME = 1;
  localparam int MODE_INVERT = 2;
  // valid, first, last, I plane, Q plane
  localparam int HIST_W = 2 * `VIS_CHANS + 3;
  // Neighbouring channels always differ
  localparam sig_word_t ALT_WORD = {(`VIS_CHANS / 2){2'b01}};

  logic      clock;
  logic      clk_rst;
  logic      mid_rst;
  logic      rst_i;
  logic      sig_valid_i;
  logic      sig_first_i;
  logic      sig_last_i;
  sig_word_t sig_dati_i;
  sig_word_t sig_datq_i;
  logic      sig_valid_o;
  logic      sig_first_o;
  logic      sig_last_o;
  sig_word_t sig_dati_o;
  sig_word_t sig_datq_o;
  logic      vis_valid_o;
  logic      vis_first_o;
  logic      vis_last_o;
  vis_t      vis_re_o;
  vis_t      vis_im_o;

  int          seed;
  int          error_count;
  int          check_count;
  int          cycle_count;
  int unsigned assert_fails;

  // Samples of the current group, and pending expected results
  sig_word_t          grp_i_q[$];
  sig_word_t          grp_q_q[$];
  int                 exp_re_q[$];
  int                 exp_im_q[$];
  int                 exp_unit_q[$];
  logic [HIST_W-1:0]  hist_q[$];

  assign rst_i = clk_rst | mid_rst;

  tb_clock u_clock (
    .clock_o(clock),
    .rst_o  (clk_rst)
  );

  vis_chain u_dut (
    .clock      (clock),
    .rst_i      (rst_i),
    .sig_valid_i(sig_valid_i),
    .sig_first_i(sig_first_i),
    .sig_last_i (sig_last_i),
    .sig_dati_i (sig_dati_i),
    .sig_datq_i (sig_datq_i),
    .sig_valid_o(sig_valid_o),
    .sig_first_o(sig_first_o),
    .sig_last_o (sig_last_o),
    .sig_dati_o (sig_dati_o),
    .sig_datq_o (sig_datq_o),
    .vis_valid_o(vis_valid_o),
    .vis_first_o(vis_first_o),
    .vis_last_o (vis_last_o),
    .vis_re_o   (vis_re_o),
    .vis_im_o   (vis_im_o)
  );

  task automatic check_value(string name, int got, int exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic int rand_range(int lo, int hi);
    int unsigned r;
    r = $unsigned($random(seed));
    return lo + int'(r % (hi - lo + 1));
  endfunction

  function automatic sig_word_t make_plane(int mode);
    logic coin;
    coin = (rand_range(0, 1) == 1);
    case (mode)
      MODE_SAME:   return {`VIS_CHANS{coin}};
      MODE_INVERT: return coin ? ALT_WORD : ~ALT_WORD;
      default:     return sig_word_t'($random(seed));
    endcase
  endfunction

  // Bit 1 is +1, bit 0 is -1
  function automatic int sign_of(logic b);
    return b ? 1 : -1;
  endfunction

  // A times conjugate B, summed over every sample of the group
  function automatic int pair_sum(int a, int b, bit imag);
    int sum;
    sum = 0;
    foreach (grp_i_q[n]) begin
      if (imag) begin
        sum += sign_of(grp_q_q[n][a]) * sign_of(grp_i_q[n][b])
             - sign_of(grp_i_q[n][a]) * sign_of(grp_q_q[n][b]);
      end else begin
        sum += sign_of(grp_i_q[n][a]) * sign_of(grp_i_q[n][b])
             + sign_of(grp_q_q[n][a]) * sign_of(grp_q_q[n][b]);
      end
    end
    return sum;
  endfunction

  task automatic push_expected();
    for (int k = 0; k < `VIS_LENGTH; k++) begin
      exp_re_q.push_back(pair_sum(k, k + 1, 1'b0));
      exp_im_q.push_back(pair_sum(k, k + 1, 1'b1));
      exp_unit_q.push_back(k);
    end
  endtask

  task automatic drive_sample(logic first, logic last, sig_word_t di, sig_word_t dq);
    @(negedge clock);
    sig_valid_i = 1'b1;
    sig_first_i = first;
    sig_last_i  = last;
    sig_dati_i  = di;
    sig_datq_i  = dq;
    grp_i_q.push_back(di);
    grp_q_q.push_back(dq);
  endtask

  // Noise on the data planes still has to pass the delay line
  task automatic drive_idle(int cycles);
    repeat (cycles) begin
      @(negedge clock);
      sig_valid_i = 1'b0;
      sig_first_i = 1'b0;
      sig_last_i  = 1'b0;
      sig_dati_i  = sig_word_t'($random(seed));
      sig_datq_i  = sig_word_t'($random(seed));
    end
  endtask

  // Fewer than VIS_COUNT frames leaves the group unfinished
  task automatic run_group(int mode, int frames);
    int len;
    grp_i_q.delete();
    grp_q_q.delete();
    for (int f = 0; f < frames; f++) begin
      len = (mode == MODE_RANDOM) ? rand_range(`VIS_LENGTH, `VIS_FRAME_MAX) : `VIS_FRAME_MAX;
      for (int n = 0; n < len; n++) begin
        drive_sample(n == 0, n == len - 1, make_plane(mode), make_plane(mode));
      end
      if (f == `VIS_COUNT - 1) begin
        push_expected();
      end
      drive_idle(rand_range(0, MAX_GAP));
    end
  endtask

  task automatic pulse_reset();
    drive_idle(2 * `VIS_LENGTH);
    mid_rst = 1'b1;
    repeat (2) @(negedge clock);
    mid_rst = 1'b0;
  endtask

  // Outputs read at the edge still hold the previous cycle's values
  always @(posedge clock) begin : delay_compare
    logic [HIST_W-1:0] old;
    if (rst_i) begin
      hist_q.delete();
    end else begin
      if (hist_q.size() == `VIS_DELAY) begin
        old = hist_q.pop_front();
        check_value("sig_valid_o", int'(sig_valid_o), int'(old[HIST_W-1]));
        check_value("sig_first_o", int'(sig_first_o), int'(old[HIST_W-2]));
        check_value("sig_last_o", int'(sig_last_o), int'(old[HIST_W-3]));
        check_value("sig_dati_o", int'(sig_dati_o), int'(old[2*`VIS_CHANS-1:`VIS_CHANS]));
        check_value("sig_datq_o", int'(sig_datq_o), int'(old[`VIS_CHANS-1:0]));
      end
      hist_q.push_back({sig_valid_i, sig_first_i, sig_last_i, sig_dati_i, sig_datq_i});
    end
  end

  always @(posedge clock) begin : vis_compare
    int unit;
    if (!rst_i && vis_valid_o) begin
      if (exp_unit_q.size() == 0) begin
        error_count++;
        $display("Visibility output appeared with no finished group pending at %0t", $time);
      end else begin
        unit = exp_unit_q.pop_front();
        check_value("vis_re_o", int'(vis_re_o), exp_re_q.pop_front());
        check_value("vis_im_o", int'(vis_im_o), exp_im_q.pop_front());
        check_value("vis_first_o", int'(vis_first_o), int'(unit == 0));
        check_value("vis_last_o", int'(vis_last_o), int'(unit == `VIS_LENGTH - 1));
      end
    end
  end

  always @(posedge clock) begin : watchdog
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles with %0d visibilities still pending, errors: %0d",
               cycle_count, exp_unit_q.size(), error_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed        = 74979;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    mid_rst     = 1'b0;
    sig_valid_i = 1'b0;
    sig_first_i = 1'b0;
    sig_last_i  = 1'b0;
    sig_dati_i  = '0;
    sig_datq_i  = '0;
    @(negedge clk_rst);
    drive_idle(2);
    repeat (RAND_GROUPS) run_group(MODE_RANDOM, `VIS_COUNT);
    // Range edges, +2 and -2 per sample over full frames
    run_group(MODE_SAME, `VIS_COUNT);
    run_group(MODE_INVERT, `VIS_COUNT);
    // Group cut short by reset, then a clean one
    run_group(MODE_RANDOM, 2);
    pulse_reset();
    run_group(MODE_RANDOM, `VIS_COUNT);
    // Last sample must not stay on the inputs while the results drain
    while (exp_unit_q.size() != 0) drive_idle(1);
    // Room for any stray output
    drive_idle(2 * `VIS_LENGTH);
    assert_fails = u_dut.u_checker.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+src
src/sig_pkg.sv
src/vis_pkg.sv
src/sig_delay.sv
src/correlator.sv
src/vis_merge.sv
src/vis_accum.sv
src/vis_chain.sv
bench/tb_clock.sv
bench/vis_chain_checker.sv
bench/vis_chain_tb.sv

/* run.sh */
#!/bin/sh
# Build the simulation with Verilator, run it, and judge the log

rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module vis_chain_tb \
  && ./obj_dir/Vvis_chain_tb +verilator+error+limit+100 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "TEST OK" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
